/* stream_mux_params.svh */
/* stream mux parameters
   stream count, FIFO depth, packet and burst sizes for the data logger mux. */
`ifndef STREAM_MUX_PARAMS_SVH
`define STREAM_MUX_PARAMS_SVH

// number of input streams.
`define STREAM_MUX_STREAMS 8
// words held by each stream FIFO.
`define STREAM_MUX_FIFO_DEPTH 32
// words in one packet, the smallest unit of a grant.
`define STREAM_MUX_PACKET_WORDS 4
// most words sent in one grant, two packets.
`define STREAM_MUX_BURST_WORDS 8

// stream select width.
`define STREAM_MUX_SEL_W ($clog2(`STREAM_MUX_STREAMS))
// fill count width, one extra bit so a full FIFO fits.
`define STREAM_MUX_COUNT_W ($clog2(`STREAM_MUX_FIFO_DEPTH) + 1)

`endif

/* stream_mux_pkg.sv */
/* stream mux package
   sample word views and arbiter state encoding. */
`default_nettype none

package stream_mux_pkg;

	// one 16-bit word, read either as a sample or as two characters.
	typedef union packed
	{
		logic [15:0] sample;
		struct packed
		{
			logic [7:0] hi;
			logic [7:0] lo;
		} chars;
	} sample_word_u;

	// arbiter FSM states.
	typedef enum logic [2:0]
	{
		ARB_IDLE  = 3'd0,
		ARB_LOAD  = 3'd1,
		ARB_FIND  = 3'd2,
		ARB_RUN   = 3'd3,
		ARB_CHECK = 3'd4
	} arb_state_e;

endpackage

`default_nettype wire

/* stream_fifo.sv */
/* stream FIFO
   circular sample buffer with push handshake, pop strobe and fill count. */
`timescale 1ns/1ps
`default_nettype none
`include "stream_mux_params.svh"

module stream_fifo
	import stream_mux_pkg::*;
(
	input  wire                            clock,
	input  wire                            resetn,
	input  wire                            i_push_valid,
	output logic                           o_push_ready,
	input  wire sample_word_u              i_push_word,
	input  wire                            i_pop,
	output sample_word_u                   o_head_word,
	output logic [`STREAM_MUX_COUNT_W-1:0] o_count
);

	localparam int PTR_W = $clog2(`STREAM_MUX_FIFO_DEPTH);
	localparam logic [`STREAM_MUX_COUNT_W-1:0] FULL_COUNT = `STREAM_MUX_FIFO_DEPTH;

	sample_word_u mem [`STREAM_MUX_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	// ready drops only while this FIFO is full.
	assign o_push_ready = (o_count != FULL_COUNT);
	assign do_push = i_push_valid && o_push_ready;
	// a pop on an empty FIFO is ignored.
	assign do_pop = i_pop && (o_count != '0);

	assign o_head_word = mem[rd_ptr];

	// sample storage.
	always_ff @(posedge clock)
	begin
		if (do_push)
			mem[wr_ptr] <= i_push_word;
	end

	// pointers wrap on their own since the depth is a power of two.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({do_push, do_pop})
				2'b10:
					o_count <= o_count + 1'b1;
				2'b01:
					o_count <= o_count - 1'b1;
				default:
					o_count <= o_count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* stream_arbiter.sv */
/* stream arbiter
   round-robin packet arbiter with a per-grant word limit. */
`timescale 1ns/1ps
`default_nettype none
`include "stream_mux_params.svh"

module stream_arbiter
	import stream_mux_pkg::*;
(
	input  wire                            clock,
	input  wire                            resetn,
	input  wire                            i_sending,
	input  wire [`STREAM_MUX_STREAMS-1:0]  i_stream_enable,
	input  wire [`STREAM_MUX_COUNT_W-1:0]  i_fifo_count [`STREAM_MUX_STREAMS],
	input  wire                            i_word_done,
	output logic                           o_grant_valid,
	output logic [`STREAM_MUX_SEL_W-1:0]   o_grant_stream
);

	localparam int PKT_W = $clog2(`STREAM_MUX_PACKET_WORDS);
	localparam int BURST_W = $clog2(`STREAM_MUX_BURST_WORDS + 1);
	localparam logic [PKT_W-1:0] PKT_LAST = PKT_W'(`STREAM_MUX_PACKET_WORDS - 1);
	localparam logic [BURST_W-1:0] BURST_LIMIT = BURST_W'(`STREAM_MUX_BURST_WORDS);
	localparam logic [`STREAM_MUX_COUNT_W-1:0] PKT_WORDS = `STREAM_MUX_PACKET_WORDS;

	arb_state_e state;
	arb_state_e state_next;

	// bit 0 of the rotating mask always belongs to the stream at index.
	logic [`STREAM_MUX_STREAMS-1:0] rot_mask;
	logic [`STREAM_MUX_SEL_W-1:0] index;
	logic [PKT_W-1:0] pkt_cnt;
	logic [BURST_W-1:0] burst_cnt;

	logic has_packet;
	logic packet_end;
	logic advance;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// eligibility and packet tracking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// partial packets stay in the FIFO until complete.
	assign has_packet = (i_fifo_count[index] >= PKT_WORDS);

	// last word of the current packet has left the serializer.
	assign packet_end = (state == ARB_RUN) && i_word_done && (pkt_cnt == PKT_LAST);

	assign o_grant_valid = (state == ARB_RUN);
	assign o_grant_stream = index;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb
	begin
		state_next = state;
		advance = 1'b0;

		case (state)
			ARB_IDLE:
			begin
				if (i_sending)
					state_next = ARB_LOAD;
			end
			ARB_LOAD:
			begin
				state_next = ARB_FIND;
			end
			ARB_FIND:
			begin
				// one stream examined per cycle.
				if (!i_sending)
					state_next = ARB_IDLE;
				else if (rot_mask[0] && has_packet)
					state_next = ARB_RUN;
				else
					advance = 1'b1;
			end
			ARB_RUN:
			begin
				// a packet is never cut short, even when sending stops.
				if (packet_end)
					state_next = ARB_CHECK;
			end
			ARB_CHECK:
			begin
				if (!i_sending)
					state_next = ARB_IDLE;
				else if (has_packet && (burst_cnt < BURST_LIMIT))
					state_next = ARB_RUN;
				else
				begin
					advance = 1'b1;
					state_next = ARB_FIND;
				end
			end
			default:
			begin
				state_next = ARB_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			state <= ARB_IDLE;
		else
			state <= state_next;
	end

	// mask and index move together so the pair stays aligned.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			rot_mask <= '0;
			index <= '0;
		end
		else if (state == ARB_IDLE)
		begin
			// every new sending period starts its search at stream 0.
			index <= '0;
		end
		else if (state == ARB_LOAD)
		begin
			rot_mask <= i_stream_enable;
		end
		else if (advance)
		begin
			rot_mask <= {rot_mask[0], rot_mask[`STREAM_MUX_STREAMS-1:1]};
			index <= index + 1'b1;
		end
	end

	// word counters for the current packet and the current grant.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			pkt_cnt <= '0;
			burst_cnt <= '0;
		end
		else if (state == ARB_FIND)
		begin
			pkt_cnt <= '0;
			burst_cnt <= '0;
		end
		else if ((state == ARB_RUN) && i_word_done)
		begin
			pkt_cnt <= packet_end ? '0 : pkt_cnt + 1'b1;
			burst_cnt <= burst_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* char_serializer.sv */
/* character serializer
   pops granted samples and sends each as a high then a low character. */
`timescale 1ns/1ps
`default_nettype none
`include "stream_mux_params.svh"

module char_serializer
	import stream_mux_pkg::*;
(
	input  wire                           clock,
	input  wire                           resetn,
	input  wire                           i_grant_valid,
	input  wire [`STREAM_MUX_SEL_W-1:0]   i_grant_stream,
	input  wire sample_word_u             i_head_word [`STREAM_MUX_STREAMS],
	output logic [`STREAM_MUX_STREAMS-1:0] o_pop,
	output logic                          o_char_valid,
	input  wire                           i_char_ready,
	output logic [7:0]                    o_char,
	output logic [`STREAM_MUX_SEL_W-1:0]  o_char_stream,
	output logic                          o_word_done
);

	sample_word_u word_q;
	logic full;
	logic low_phase;
	logic load;
	logic accept;

	// a new word is taken only once the holding register is empty.
	assign load = i_grant_valid && !full;
	assign accept = full && i_char_ready;
	assign o_word_done = accept && low_phase;

	assign o_char_valid = full;
	assign o_char = low_phase ? word_q.chars.lo : word_q.chars.hi;

	// one-hot pop to the granted FIFO.
	always_comb
	begin
		o_pop = '0;
		if (load)
			o_pop[i_grant_stream] = 1'b1;
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			full <= 1'b0;
			low_phase <= 1'b0;
		end
		else if (load)
		begin
			full <= 1'b1;
			low_phase <= 1'b0;
		end
		else if (accept)
		begin
			// high character gone, low one next, then empty.
			full <= !low_phase;
			low_phase <= 1'b1;
		end
	end

	// word and its stream tag are captured together.
	always_ff @(posedge clock)
	begin
		if (load)
		begin
			word_q <= i_head_word[i_grant_stream];
			o_char_stream <= i_grant_stream;
		end
	end

endmodule

`default_nettype wire

/* stream_mux_top.sv */
/* stream mux top level
   eight sample FIFOs, the packet arbiter and the character serializer. */
`timescale 1ns/1ps
`default_nettype none
`include "stream_mux_params.svh"

module stream_mux_top
	import stream_mux_pkg::*;
(
	input  wire                           clock,
	input  wire                           resetn,

	input  wire                           i_push_valid,
	input  wire [`STREAM_MUX_SEL_W-1:0]   i_push_stream,
	input  wire [15:0]                    i_push_word,
	output logic                          o_push_ready,

	input  wire [`STREAM_MUX_STREAMS-1:0] i_stream_enable,
	input  wire                           i_sending,

	output logic                          o_char_valid,
	input  wire                           i_char_ready,
	output logic [7:0]                    o_char,
	output logic [`STREAM_MUX_SEL_W-1:0]  o_char_stream
);

	sample_word_u push_word;

	wire [`STREAM_MUX_STREAMS-1:0] fifo_ready;
	wire [`STREAM_MUX_STREAMS-1:0] pop;
	wire [`STREAM_MUX_COUNT_W-1:0] fifo_count [`STREAM_MUX_STREAMS];
	wire sample_word_u head_word [`STREAM_MUX_STREAMS];

	wire grant_valid;
	wire [`STREAM_MUX_SEL_W-1:0] grant_stream;
	wire word_done;

	assign push_word.sample = i_push_word;

	// ready follows the FIFO that the pusher addresses.
	assign o_push_ready = fifo_ready[i_push_stream];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per-stream FIFOs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar g = 0; g < `STREAM_MUX_STREAMS; g++)
	begin : gen_fifo
		stream_fifo u_fifo
		(
			.clock        (clock),
			.resetn       (resetn),
			.i_push_valid (i_push_valid && (i_push_stream == g)),
			.o_push_ready (fifo_ready[g]),
			.i_push_word  (push_word),
			.i_pop        (pop[g]),
			.o_head_word  (head_word[g]),
			.o_count      (fifo_count[g])
		);
	end

	stream_arbiter u_arbiter
	(
		.clock           (clock),
		.resetn          (resetn),
		.i_sending       (i_sending),
		.i_stream_enable (i_stream_enable),
		.i_fifo_count    (fifo_count),
		.i_word_done     (word_done),
		.o_grant_valid   (grant_valid),
		.o_grant_stream  (grant_stream)
	);

	char_serializer u_serializer
	(
		.clock          (clock),
		.resetn         (resetn),
		.i_grant_valid  (grant_valid),
		.i_grant_stream (grant_stream),
		.i_head_word    (head_word),
		.o_pop          (pop),
		.o_char_valid   (o_char_valid),
		.i_char_ready   (i_char_ready),
		.o_char         (o_char),
		.o_char_stream  (o_char_stream),
		.o_word_done    (word_done)
	);

endmodule

`default_nettype wire

/* stream_mux_tb.sv */
/* stream mux testbench
   replays the command file, checks every character and applies random back-pressure. */
`timescale 1ns/1ps
`default_nettype none
`include "stream_mux_params.svh"

module stream_mux_tb
	import stream_mux_pkg::*;
();

	localparam int CMD_DEPTH = 512;

	logic clock;
	logic resetn;
	logic i_push_valid;
	logic [`STREAM_MUX_SEL_W-1:0] i_push_stream;
	logic [15:0] i_push_word;
	logic o_push_ready;
	logic [`STREAM_MUX_STREAMS-1:0] i_stream_enable;
	logic i_sending;
	logic o_char_valid;
	logic i_char_ready;
	logic [7:0] o_char;
	logic [`STREAM_MUX_SEL_W-1:0] o_char_stream;

	// each entry is command, stream and 16-bit data.
	logic [23:0] cmd_mem [CMD_DEPTH];
	// expected characters as stream and character.
	logic [10:0] exp_q [$];
	logic [10:0] exp_item;
	// character held back by the last stall.
	logic stall_pending;
	logic [7:0] stall_char;
	logic [`STREAM_MUX_SEL_W-1:0] stall_stream;
	logic bp_mode;
	integer seed = 25;
	integer rnd;
	int error_count;
	int check_count;
	int cycle_count;
	int cycle_limit;
	arb_state_e hang_state;

	stream_mux_top dut
	(
		.clock           (clock),
		.resetn          (resetn),
		.i_push_valid    (i_push_valid),
		.i_push_stream   (i_push_stream),
		.i_push_word     (i_push_word),
		.o_push_ready    (o_push_ready),
		.i_stream_enable (i_stream_enable),
		.i_sending       (i_sending),
		.o_char_valid    (o_char_valid),
		.i_char_ready    (i_char_ready),
		.o_char          (o_char),
		.o_char_stream   (o_char_stream)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#4 clock = ~clock;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic compare_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("ERR %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
		end
	endtask

	// valid and data stay up until the word is taken.
	task automatic push_word(input logic [`STREAM_MUX_SEL_W-1:0] stream,
		input logic [15:0] word);
		i_push_valid <= 1'b1;
		i_push_stream <= stream;
		i_push_word <= word;
		@(negedge clock);
		while (!o_push_ready)
			@(negedge clock);
		@(posedge clock);
	endtask

	task automatic check_push_ready(input logic [`STREAM_MUX_SEL_W-1:0] stream,
		input logic expected);
		i_push_stream <= stream;
		@(negedge clock);
		compare_value("o_push_ready", o_push_ready, expected);
		@(posedge clock);
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0)
			@(posedge clock);
		// a stray extra character still shows up in this quiet period.
		repeat (20)
			@(posedge clock);
	endtask

	// random back-pressure with ready high about three cycles in four.
	always @(posedge clock)
	begin
		if (bp_mode)
		begin
			rnd = $random(seed);
			i_char_ready <= rnd[0] | rnd[1];
		end
		else
			i_char_ready <= 1'b1;
	end

	// a character moves on the next rising edge when valid and ready are high.
	always @(negedge clock)
	begin
		// a character that was held back must still be offered unchanged.
		if (stall_pending)
		begin
			compare_value("o_char_valid", o_char_valid, 1'b1);
			compare_value("o_char_stream", o_char_stream, stall_stream);
			compare_value("o_char", o_char, stall_char);
		end
		stall_pending = resetn && o_char_valid && !i_char_ready;
		stall_stream = o_char_stream;
		stall_char = o_char;

		if (resetn && o_char_valid && i_char_ready)
		begin
			if (exp_q.size() == 0)
			begin
				error_count++;
				$display("character 0x%h arrived on stream %0d while none was expected",
					o_char, o_char_stream);
			end
			else
			begin
				exp_item = exp_q.pop_front();
				compare_value("o_char_stream", o_char_stream, exp_item[10:8]);
				compare_value("o_char", o_char, exp_item[7:0]);
			end
		end
	end

	initial
	begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit)
		begin
			@(posedge clock);
			cycle_count++;
		end
		error_count++;
		hang_state = dut.u_arbiter.state;
		$display("hang: run stopped after %0d cycles with the arbiter in state %s",
			cycle_count, hang_state.name());
		$display("closing: %0d errors in %0d checks", error_count, check_count);
		$display("ERRORS FOUND");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// command replay
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		int pc;
		int n_chars;
		int n_pushes;
		logic [23:0] cmd;
		logic done;

		resetn = 1'b0;
		i_push_valid = 1'b0;
		i_push_stream = '0;
		i_push_word = '0;
		i_stream_enable = '0;
		i_sending = 1'b0;
		i_char_ready = 1'b0;
		bp_mode = 1'b0;
		stall_pending = 1'b0;

		$readmemh("stream_mux_testdata.txt", cmd_mem);
		n_chars = 0;
		n_pushes = 0;
		for (pc = 0; pc < CMD_DEPTH; pc++)
		begin
			if (cmd_mem[pc][23:20] == 4'h1)
				n_pushes++;
			else if (cmd_mem[pc][23:20] == 4'h6)
				n_chars++;
		end
		cycle_limit = 40 * n_chars + 20 * n_pushes + 200;

		repeat (2)
			@(posedge clock);
		resetn <= 1'b1;

		pc = 0;
		done = 1'b0;
		while (!done)
		begin
			cmd = (pc < CMD_DEPTH) ? cmd_mem[pc] : 24'hF00000;
			pc++;
			i_push_valid <= 1'b0;
			case (cmd[23:20])
				4'h1: push_word(cmd[18:16], cmd[15:0]);
				4'h2: i_stream_enable <= cmd[7:0];
				4'h3: i_sending <= 1'b1;
				4'h4: i_sending <= 1'b0;
				4'h5: wait_drained();
				4'h6: exp_q.push_back({cmd[18:16], cmd[7:0]});
				4'h7: bp_mode <= cmd[0];
				4'h8: check_push_ready(cmd[18:16], cmd[0]);
				4'hF: done = 1'b1;
				default:
				begin
					error_count++;
					$display("unknown command 0x%h at entry %0d of the data file", cmd, pc - 1);
					done = 1'b1;
				end
			endcase
		end

		if (exp_q.size() != 0)
		begin
			error_count++;
			$display("%0d expected characters never arrived", exp_q.size());
		end
		$display("closing: %0d errors in %0d checks", error_count, check_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* stream_mux_testdata.txt */
// entry = six hex digits: command, stream, 16-bit data. 1 push word, 2 enable mask,
// 3 start, 4 stop, 5 wait until drained, 6 expect character (low byte of data),
// 7 back-pressure on (data 1) or off, 8 check push ready of stream (data bit 0), F end.
// stream 2 alone, one packet, always ready
1221A0 1221A1 1221A2 1221A3
200004 700000 300000
620021 6200A0 620021 6200A1 620021 6200A2 620021 6200A3
500000 400000
// streams 0, 1 and 5 enabled, stream 4 holds a packet but is disabled
1001A0 1001A1 1001A2 1001A3 1111A0 1111A1 1111A2 1111A3
1441A0 1441A1 1441A2 1441A3 1551A0 1551A1 1551A2 1551A3
200023 300000
600001 6000A0 600001 6000A1 600001 6000A2 600001 6000A3
610011 6100A0 610011 6100A1 610011 6100A2 610011 6100A3
650051 6500A0 650051 6500A1 650051 6500A2 650051 6500A3
500000 400000
// stream 1 three packets, stream 6 one packet, burst limit, back-pressure from here on
1112A0 1112A1 1112A2 1112A3 1113A0 1113A1 1113A2 1113A3
1114A0 1114A1 1114A2 1114A3 1662A0 1662A1 1662A2 1662A3
200042 700001 300000
610012 6100A0 610012 6100A1 610012 6100A2 610012 6100A3
610013 6100A0 610013 6100A1 610013 6100A2 610013 6100A3
660062 6600A0 660062 6600A1 660062 6600A2 660062 6600A3
610014 6100A0 610014 6100A1 610014 6100A2 610014 6100A3
500000 400000
// stream 3 partial packet waits, stream 7 goes first, then stream 3 completes
1333A0 1333A1 1773A0 1773A1 1773A2 1773A3
200088 300000
670073 6700A0 670073 6700A1 670073 6700A2 670073 6700A3
500000 400000
1333A2 1333A3 300000
630033 6300A0 630033 6300A1 630033 6300A2 630033 6300A3
500000 400000
// stream 0 fresh packet, then the stream 4 packet left from before
1005A0 1005A1 1005A2 1005A3 200011 300000
600005 6000A0 600005 6000A1 600005 6000A2 600005 6000A3
640041 6400A0 640041 6400A1 640041 6400A2 640041 6400A3
500000 400000
// stream 5 filled to 32 words with sending off, then drained
1550C0 1550C1 1550C2 1550C3 1551C0 1551C1 1551C2 1551C3
1552C0 1552C1 1552C2 1552C3 1553C0 1553C1 1553C2 1553C3
1554C0 1554C1 1554C2 1554C3 1555C0 1555C1 1555C2 1555C3
1556C0 1556C1 1556C2 1556C3 1557C0 1557C1 1557C2 1557C3
850000 840001 200020 300000
650050 6500C0 650050 6500C1 650050 6500C2 650050 6500C3
650051 6500C0 650051 6500C1 650051 6500C2 650051 6500C3
650052 6500C0 650052 6500C1 650052 6500C2 650052 6500C3
650053 6500C0 650053 6500C1 650053 6500C2 650053 6500C3
650054 6500C0 650054 6500C1 650054 6500C2 650054 6500C3
650055 6500C0 650055 6500C1 650055 6500C2 650055 6500C3
650056 6500C0 650056 6500C1 650056 6500C2 650056 6500C3
650057 6500C0 650057 6500C1 650057 6500C2 650057 6500C3
500000 400000
F00000

/* src.f */
+incdir+.
stream_mux_pkg.sv
stream_fifo.sv
stream_arbiter.sv
char_serializer.sv
stream_mux_top.sv
stream_mux_tb.sv
